// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_stepper_controller \
  -f tb.f -o tb_sim

status=0
./obj_dir/tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -q "RESULT: PASS" sim.log; then
  exit 0
fi
echo "simulation failed"
exit 1

// File: src/axis_ctrl_if.sv
`timescale 1ns/100ps

interface axis_ctrl_if #(
  parameter int MOTOR_COUNT = 2
);

  logic                   tick;
  logic                   load;
  logic                   run;
  // Parameters of the move in progress
  stepper_pkg::word_t     increment [MOTOR_COUNT];
  stepper_pkg::word_t     accel [MOTOR_COUNT];
  logic [MOTOR_COUNT-1:0] dir;

  modport sequencer (output tick, load, run, increment, accel, dir);

  modport axis (input tick, load, run, increment, accel, dir);

endinterface

// File: src/command_decoder.sv
`timescale 1ns/100ps

module command_decoder #(
  parameter int MOTOR_COUNT        = 2,
  parameter int MOVE_DURATION_BITS = 32
) (
  input  logic                   CLK,
  input  logic                   resetn,
  input  stepper_pkg::word_t     rx_word,
  input  logic                   word_received,
  output stepper_pkg::word_t     tx_word,
  input  logic signed [31:0]     step_count [MOTOR_COUNT],
  output logic [MOTOR_COUNT-1:0] enable,
  output logic [7:0]             divisor,
  move_write_if.decoder          mw
);

  localparam int AXIS_BITS = stepper_pkg::index_bits(MOTOR_COUNT);
  // Header, duration, then increment and accel per axis
  localparam logic [7:0] LAST_WORD = 8'(2 * MOTOR_COUNT + 1);

  logic [7:0]         msg_header;
  logic [7:0]         word_count;
  logic               move_ok;
  logic               pending;
  logic               is_move_header;
  logic [7:0]         field_axis;
  logic signed [31:0] snapshot [MOTOR_COUNT];
  stepper_pkg::word_t next_snapshot;

  assign pending = (msg_header == stepper_pkg::CMD_COORDINATED_STEP) ||
                   (msg_header == stepper_pkg::CMD_API_VERSION);
  assign is_move_header = (rx_word[63:56] == stepper_pkg::CMD_COORDINATED_STEP);

  // Words 2,3 belong to axis 0, words 4,5 to axis 1 and so on
  assign field_axis = (word_count - 8'd2) >> 1;

  // Reply after the accel word of an axis is the next axis' count
  always_comb begin
    next_snapshot = '0;
    for (int n = 0; n < MOTOR_COUNT - 1; n++) begin
      if (field_axis == 8'(n)) begin
        next_snapshot = {{32{snapshot[n + 1][31]}}, snapshot[n + 1]};
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      tx_word    <= '0;
      enable     <= '0;
      divisor    <= stepper_pkg::DEFAULT_DIVISOR;
      msg_header <= '0;
      word_count <= '0;
      move_ok    <= 1'b0;
      mw.wr      <= 1'b0;
      mw.commit  <= 1'b0;
    end else begin
      mw.wr     <= 1'b0;
      mw.commit <= 1'b0;
      if (word_received) begin
        tx_word <= '0;
        if (!pending) begin
          msg_header <= rx_word[63:56];
          word_count <= 8'd1;
          case (rx_word[63:56])
            stepper_pkg::CMD_COORDINATED_STEP: begin
              // Full buffer drops the whole move
              move_ok <= mw.slot_free;
              mw.wr   <= mw.slot_free;
            end
            stepper_pkg::CMD_MOTOR_ENABLE: enable <= rx_word[MOTOR_COUNT-1:0];
            stepper_pkg::CMD_CLK_DIVISOR:  divisor <= rx_word[7:0];
            stepper_pkg::CMD_API_VERSION: begin
              tx_word[31:0] <= {stepper_pkg::VERSION_DEVEL, stepper_pkg::VERSION_MAJOR,
                                stepper_pkg::VERSION_MINOR, stepper_pkg::VERSION_PATCH};
            end
            default: ;
          endcase
        end else if (msg_header == stepper_pkg::CMD_COORDINATED_STEP) begin
          word_count <= word_count + 8'd1;
          mw.wr      <= move_ok;
          if (word_count == 8'd1) begin
            tx_word <= {{32{snapshot[0][31]}}, snapshot[0]};
          end else if (word_count[0]) begin
            tx_word <= next_snapshot;
          end
          if (word_count == LAST_WORD) begin
            mw.commit  <= move_ok;
            msg_header <= '0;
            word_count <= '0;
          end
        end else begin
          // Second word of a version request is a dummy
          msg_header <= '0;
          word_count <= '0;
        end
      end
    end
  end

  // Field payload and the step count snapshot
  always_ff @(posedge CLK) begin
    if (word_received) begin
      mw.axis <= field_axis[AXIS_BITS-1:0];
      mw.data <= rx_word;
      if (!pending) begin
        mw.field <= stepper_pkg::FIELD_DIR;
        if (is_move_header) begin
          snapshot <= step_count;
        end
      end else if (word_count == 8'd1) begin
        mw.field <= stepper_pkg::FIELD_DURATION;
        mw.data  <= stepper_pkg::word_t'(rx_word[MOVE_DURATION_BITS-1:0]);
      end else if (word_count[0]) begin
        mw.field <= stepper_pkg::FIELD_ACCEL;
      end else begin
        mw.field <= stepper_pkg::FIELD_INCREMENT;
      end
    end
  end

endmodule

// File: src/dda_axis.sv
`timescale 1ns/100ps

module dda_axis #(
  parameter int AXIS        = 0,
  parameter int MOTOR_COUNT = 2
) (
  input  logic               CLK,
  input  logic               resetn,
  axis_ctrl_if.axis          ax,
  output logic               step,
  output logic signed [31:0] step_count
);

  // Stay inside the interface arrays
  localparam int SEL = (AXIS < MOTOR_COUNT) ? AXIS : MOTOR_COUNT - 1;

  // 32.32 fixed point position and velocity
  logic [63:0] accum;
  logic [63:0] velocity;
  logic [63:0] accum_next;
  logic        advance;
  logic        crossed;

  assign accum_next = accum + velocity;
  assign advance    = ax.tick && ax.run;
  assign crossed    = accum_next[63:32] > accum[63:32];

  always_ff @(posedge CLK) begin
    if (ax.load) begin
      accum    <= '0;
      velocity <= ax.increment[SEL];
    end else if (advance) begin
      accum    <= accum_next;
      velocity <= velocity + ax.accel[SEL];
    end
  end

  // Step shows the cycle after its tick
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      step       <= 1'b0;
      step_count <= '0;
    end else begin
      step <= advance && crossed;
      if (advance && crossed) begin
        if (ax.dir[SEL]) begin
          step_count <= step_count + 32'sd1;
        end else begin
          step_count <= step_count - 32'sd1;
        end
      end
    end
  end

endmodule

// File: src/move_sequencer.sv
`timescale 1ns/100ps

module move_sequencer #(
  parameter int MOTOR_COUNT        = 2,
  parameter int MOVE_DURATION_BITS = 32
) (
  input  logic          CLK,
  input  logic          resetn,
  input  logic [7:0]    divisor,
  move_write_if.sequencer mw,
  axis_ctrl_if.sequencer  ax,
  output logic          buffer_dtr,
  output logic          move_done
);

  localparam int SLOTS    = stepper_pkg::BUFFER_SLOTS;
  localparam int PTR_BITS = stepper_pkg::index_bits(SLOTS);

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    RUN
  } state_e;

  state_e                        state;
  logic [PTR_BITS-1:0]           wr_ptr;
  logic [PTR_BITS-1:0]           rd_ptr;
  logic [SLOTS-1:0]              full;
  logic [7:0]                    div_cnt;
  logic [MOVE_DURATION_BITS-1:0] ticks_left;

  // Move storage
  logic [MOTOR_COUNT-1:0]        dir_mem [SLOTS];
  logic [MOVE_DURATION_BITS-1:0] duration_mem [SLOTS];
  stepper_pkg::word_t            inc_mem [SLOTS][MOTOR_COUNT];
  stepper_pkg::word_t            acc_mem [SLOTS][MOTOR_COUNT];

  // Slots fill in order, so a free slot is always the write slot
  assign mw.slot_free = ~full[wr_ptr];
  assign buffer_dtr   = ~full[wr_ptr];

  assign ax.dir = dir_mem[rd_ptr];
  for (genvar a = 0; a < MOTOR_COUNT; a++) begin : g_active
    assign ax.increment[a] = inc_mem[rd_ptr][a];
    assign ax.accel[a]     = acc_mem[rd_ptr][a];
  end

  always_ff @(posedge CLK) begin
    if (mw.wr) begin
      case (mw.field)
        stepper_pkg::FIELD_DIR:       dir_mem[wr_ptr] <= mw.data[MOTOR_COUNT-1:0];
        stepper_pkg::FIELD_DURATION:  duration_mem[wr_ptr] <= mw.data[MOVE_DURATION_BITS-1:0];
        stepper_pkg::FIELD_INCREMENT: inc_mem[wr_ptr][mw.axis] <= mw.data;
        stepper_pkg::FIELD_ACCEL:     acc_mem[wr_ptr][mw.axis] <= mw.data;
        default: ;
      endcase
    end
  end

  // Free running DDA tick, one every divisor cycles
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      div_cnt <= '0;
      ax.tick <= 1'b0;
    end else if (div_cnt >= divisor - 8'd1) begin
      div_cnt <= '0;
      ax.tick <= 1'b1;
    end else begin
      div_cnt <= div_cnt + 8'd1;
      ax.tick <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state      <= IDLE;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      full       <= '0;
      ticks_left <= '0;
      ax.load    <= 1'b0;
      ax.run     <= 1'b0;
      move_done  <= 1'b0;
    end else begin
      ax.load   <= 1'b0;
      move_done <= 1'b0;
      if (mw.commit) begin
        full[wr_ptr] <= 1'b1;
        wr_ptr       <= (wr_ptr == PTR_BITS'(SLOTS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      case (state)
        IDLE: begin
          if (full[rd_ptr]) begin
            ax.load <= 1'b1;
            state   <= LOAD;
          end
        end
        LOAD: begin
          ticks_left <= duration_mem[rd_ptr];
          ax.run     <= 1'b1;
          state      <= RUN;
        end
        RUN: begin
          if (ticks_left == '0) begin
            // Release the slot and start looking for the next move
            ax.run       <= 1'b0;
            move_done    <= 1'b1;
            full[rd_ptr] <= 1'b0;
            rd_ptr       <= (rd_ptr == PTR_BITS'(SLOTS - 1)) ? '0 : rd_ptr + 1'b1;
            state        <= IDLE;
          end else if (ax.tick) begin
            ticks_left <= ticks_left - 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: src/move_write_if.sv
`timescale 1ns/100ps

interface move_write_if #(
  parameter int MOTOR_COUNT = 2
);

  logic                                               wr;
  stepper_pkg::field_e                                field;
  logic [stepper_pkg::index_bits(MOTOR_COUNT)-1:0]    axis;
  stepper_pkg::word_t                                 data;
  logic                                               commit;
  logic                                               slot_free;

  modport decoder (output wr, field, axis, data, commit, input slot_free);

  modport sequencer (input wr, field, axis, data, commit, output slot_free);

endinterface

// File: src/spi_word.sv
`timescale 1ns/100ps

module spi_word (
  input  logic               CLK,
  input  logic               resetn,
  input  logic               sck,
  input  logic               cs_n,
  input  logic               copi,
  output logic               cipo,
  input  stepper_pkg::word_t tx_word,
  output stepper_pkg::word_t rx_word,
  output logic               word_received
);

  logic [2:0]         sck_sync;
  logic [1:0]         cs_sync;
  logic [1:0]         copi_sync;
  logic               sck_rise;
  logic               sck_fall;
  logic               cs_active;
  logic [5:0]         bit_cnt;
  stepper_pkg::word_t rx_shift;
  stepper_pkg::word_t tx_shift;

  // Edges seen on the synchronised SCK, copi delayed to match
  assign sck_rise  = sck_sync[1] & ~sck_sync[2];
  assign sck_fall  = ~sck_sync[1] & sck_sync[2];
  assign cs_active = ~cs_sync[1];
  assign cipo      = tx_shift[63];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_sync  <= 3'b000;
      cs_sync   <= 2'b11;
      copi_sync <= 2'b00;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[0], cs_n};
      copi_sync <= {copi_sync[0], copi};
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt       <= '0;
      word_received <= 1'b0;
      tx_shift      <= '0;
    end else begin
      word_received <= 1'b0;
      if (!cs_active) begin
        // Idle frame, keep the reply ready for the first bit
        bit_cnt  <= '0;
        tx_shift <= tx_word;
      end else begin
        if (sck_rise) begin
          bit_cnt       <= bit_cnt + 6'd1;
          word_received <= (bit_cnt == 6'd63);
        end
        // Mode 0 changes data on the falling edge
        if (sck_fall) begin
          if (bit_cnt == 6'd0) begin
            tx_shift <= tx_word;
          end else begin
            tx_shift <= {tx_shift[62:0], 1'b0};
          end
        end
      end
    end
  end

  // MSB first
  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[62:0], copi_sync[1]};
      if (bit_cnt == 6'd63) begin
        rx_word <= {rx_shift[62:0], copi_sync[1]};
      end
    end
  end

endmodule

// File: src/stepper_controller.sv
`timescale 1ns/100ps

module stepper_controller #(
  parameter int MOTOR_COUNT        = 2,
  parameter int MOVE_DURATION_BITS = 32
) (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   sck,
  input  logic                   cs_n,
  input  logic                   copi,
  output logic                   cipo,
  output logic [MOTOR_COUNT-1:0] step,
  output logic [MOTOR_COUNT-1:0] dir,
  output logic [MOTOR_COUNT-1:0] enable,
  output logic                   buffer_dtr,
  output logic                   move_done
);

  stepper_pkg::word_t rx_word;
  stepper_pkg::word_t tx_word;
  logic               word_received;
  logic [7:0]         divisor;
  logic signed [31:0] step_count [MOTOR_COUNT];

  move_write_if #(.MOTOR_COUNT(MOTOR_COUNT)) mw_if ();
  axis_ctrl_if #(.MOTOR_COUNT(MOTOR_COUNT)) ax_if ();

  assign dir = ax_if.dir;

  spi_word spi_word_inst (
    .CLK          (CLK),
    .resetn       (resetn),
    .sck          (sck),
    .cs_n         (cs_n),
    .copi         (copi),
    .cipo         (cipo),
    .tx_word      (tx_word),
    .rx_word      (rx_word),
    .word_received(word_received)
  );

  command_decoder #(
    .MOTOR_COUNT       (MOTOR_COUNT),
    .MOVE_DURATION_BITS(MOVE_DURATION_BITS)
  ) command_decoder_inst (
    .CLK          (CLK),
    .resetn       (resetn),
    .rx_word      (rx_word),
    .word_received(word_received),
    .tx_word      (tx_word),
    .step_count   (step_count),
    .enable       (enable),
    .divisor      (divisor),
    .mw           (mw_if)
  );

  move_sequencer #(
    .MOTOR_COUNT       (MOTOR_COUNT),
    .MOVE_DURATION_BITS(MOVE_DURATION_BITS)
  ) move_sequencer_inst (
    .CLK       (CLK),
    .resetn    (resetn),
    .divisor   (divisor),
    .mw        (mw_if),
    .ax        (ax_if),
    .buffer_dtr(buffer_dtr),
    .move_done (move_done)
  );

  // One DDA engine per motor
  for (genvar i = 0; i < MOTOR_COUNT; i++) begin : g_axis
    dda_axis #(
      .AXIS       (i),
      .MOTOR_COUNT(MOTOR_COUNT)
    ) dda_axis_inst (
      .CLK       (CLK),
      .resetn    (resetn),
      .ax        (ax_if),
      .step      (step[i]),
      .step_count(step_count[i])
    );
  end

endmodule

// File: src/stepper_pkg.sv
package stepper_pkg;

  // One SPI transfer unit
  typedef logic [63:0] word_t;

  // Header opcodes, carried in bits 63:56
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,
    CMD_MOTOR_ENABLE     = 8'h0A,
    CMD_CLK_DIVISOR      = 8'h0C,
    CMD_API_VERSION      = 8'hFE
  } cmd_e;

  // Part of a buffered move being written
  typedef enum logic [1:0] {
    FIELD_DIR,
    FIELD_DURATION,
    FIELD_INCREMENT,
    FIELD_ACCEL
  } field_e;

  // Reported by CMD_API_VERSION
  localparam logic [7:0] VERSION_MAJOR = 8'd1;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd0;
  localparam logic [7:0] VERSION_DEVEL = 8'd1;

  localparam int BUFFER_SLOTS = 2;

  // Ticks at CLK / 40 out of reset
  localparam logic [7:0] DEFAULT_DIVISOR = 8'd40;

  // Index width for an array of count entries, at least one bit
  function automatic int index_bits(input int count);
    int bits;
    bits = (count > 1) ? $clog2(count) : 1;
    return bits;
  endfunction

endpackage

// File: tb.f
src/stepper_pkg.sv
src/move_write_if.sv
src/axis_ctrl_if.sv
src/spi_word.sv
src/command_decoder.sv
src/move_sequencer.sv
src/dda_axis.sv
src/stepper_controller.sv
tests/stepper_properties.sv
tests/stepper_checker.sv
tests/tb_stepper_controller.sv

// File: tests/stepper_checker.sv
`timescale 1ns/100ps

module stepper_checker #(
  parameter int MOTOR_COUNT = 2
) (
  input logic                   CLK,
  input logic                   resetn,
  input logic [MOTOR_COUNT-1:0] step,
  input logic                   buffer_dtr,
  input logic                   move_done
);

  int     step_total [MOTOR_COUNT];
  int     done_count;
  int     dtr_falls;
  longint cycle;
  longint last_rise_cycle;
  longint last_done_cycle;
  logic   dtr_q;
  int     error_count = 0;
  int     test_errors = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;

  // Running totals seen on the DUT ports
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      for (int a = 0; a < MOTOR_COUNT; a++) begin
        step_total[a] <= 0;
      end
      done_count      <= 0;
      dtr_falls       <= 0;
      cycle           <= 0;
      last_rise_cycle <= 0;
      last_done_cycle <= 0;
      dtr_q           <= 1'b1;
    end else begin
      cycle <= cycle + 1;
      for (int a = 0; a < MOTOR_COUNT; a++) begin
        if (step[a]) begin
          step_total[a] <= step_total[a] + 1;
        end
      end
      if (move_done) begin
        done_count      <= done_count + 1;
        last_done_cycle <= cycle;
      end
      if (buffer_dtr && !dtr_q) begin
        last_rise_cycle <= cycle;
      end
      if (!buffer_dtr && dtr_q) begin
        dtr_falls <= dtr_falls + 1;
      end
      dtr_q <= buffer_dtr;
    end
  end

  task automatic compare(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic compare_range(input string name, input longint low, input longint high,
                               input longint actual);
    if (actual < low || actual > high) begin
      $display("FAIL %s: expected %0d to %0d, actual %0d", name, low, high, actual);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic record_failure(input string what);
    $display("%s", what);
    error_count++;
    test_errors++;
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      $display("PASS %s", name);
      tests_passed++;
    end else begin
      $display("FAIL %s with %0d mismatches", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  task automatic report();
    $display("Tests: %0d passed, %0d failed, %0d check errors",
             tests_passed, tests_failed, error_count);
  endtask

endmodule

// File: tests/stepper_properties.sv
`timescale 1ns/100ps

module stepper_properties #(
  parameter int MOTOR_COUNT = 2
) (
  input logic                   CLK,
  input logic                   resetn,
  input logic                   move_done,
  input logic                   commit,
  input logic                   slot_free,
  input logic [MOTOR_COUNT-1:0] step
);

  a_done_pulse: assert property (@(posedge CLK) disable iff (!resetn)
    move_done |=> !move_done)
    else $error("move_done held for more than one cycle");

  a_commit_free: assert property (@(posedge CLK) disable iff (!resetn)
    commit |-> slot_free)
    else $error("move committed while no buffer slot was free");

  // No axis steps on two cycles in a row
  a_step_pulse: assert property (@(posedge CLK) disable iff (!resetn)
    (step != '0) |=> ((step & $past(step)) == '0))
    else $error("step pulse held for more than one cycle");

endmodule

bind move_sequencer stepper_properties #(
  .MOTOR_COUNT(MOTOR_COUNT)
) stepper_properties_inst (
  .CLK      (CLK),
  .resetn   (resetn),
  .move_done(move_done),
  .commit   (mw.commit),
  .slot_free(mw.slot_free),
  .step     (stepper_controller.step)
);

// File: tests/tb_stepper_controller.sv
`timescale 1ns/100ps

module tb_stepper_controller;

  localparam int MOTORS       = 2;
  localparam int MOVE_WORDS   = 2 + 2 * MOTORS;
  localparam int DONE_TIMEOUT = 100000;

  logic              CLK;
  logic              resetn;
  logic              sck;
  logic              cs_n;
  logic              copi;
  logic              cipo;
  logic [MOTORS-1:0] step;
  logic [MOTORS-1:0] dir;
  logic [MOTORS-1:0] enable;
  logic              buffer_dtr;
  logic              move_done;

  int                 seed;
  logic signed [31:0] position [MOTORS];
  stepper_pkg::word_t reply [MOVE_WORDS];

  always #2 CLK = ~CLK;

  stepper_controller #(
    .MOTOR_COUNT       (MOTORS),
    .MOVE_DURATION_BITS(32)
  ) stepper_controller_inst (
    .CLK       (CLK),
    .resetn    (resetn),
    .sck       (sck),
    .cs_n      (cs_n),
    .copi      (copi),
    .cipo      (cipo),
    .step      (step),
    .dir       (dir),
    .enable    (enable),
    .buffer_dtr(buffer_dtr),
    .move_done (move_done)
  );

  stepper_checker #(.MOTOR_COUNT(MOTORS)) scoreboard_inst (
    .CLK       (CLK),
    .resetn    (resetn),
    .step      (step),
    .buffer_dtr(buffer_dtr),
    .move_done (move_done)
  );

  // Integer part of the 32.32 position after the given number of ticks
  function automatic int expected_steps(input logic [63:0] inc, input logic [63:0] acc,
                                        input int ticks);
    logic [63:0] vel;
    logic [63:0] pos;
    vel = inc;
    pos = '0;
    for (int t = 0; t < ticks; t++) begin
      pos = pos + vel;
      vel = vel + acc;
    end
    return int'(pos[63:32]);
  endfunction

  task automatic wait_clks(input int n);
    repeat (n) @(posedge CLK);
  endtask

  // Mode 0 host, 4 CLK per SCK phase, one word per CS frame
  task automatic spi_xfer(input stepper_pkg::word_t tx, output stepper_pkg::word_t rx);
    rx = '0;
    @(posedge CLK);
    cs_n <= 1'b0;
    copi <= tx[63];
    for (int i = 63; i >= 0; i--) begin
      wait_clks(4);
      sck <= 1'b1;
      rx = {rx[62:0], cipo};
      wait_clks(4);
      sck <= 1'b0;
      if (i > 0) begin
        copi <= tx[i-1];
      end
    end
    wait_clks(4);
    cs_n <= 1'b1;
    wait_clks(8);
  endtask

  task automatic send_move(input logic [MOTORS-1:0] dirs, input int ticks,
                           input stepper_pkg::word_t inc [MOTORS],
                           input stepper_pkg::word_t acc [MOTORS]);
    stepper_pkg::word_t words [MOVE_WORDS];
    words[0] = {stepper_pkg::CMD_COORDINATED_STEP, 56'(dirs)};
    words[1] = 64'(ticks);
    for (int a = 0; a < MOTORS; a++) begin
      words[2 + 2 * a] = inc[a];
      words[3 + 2 * a] = acc[a];
    end
    for (int k = 0; k < MOVE_WORDS; k++) begin
      spi_xfer(words[k], reply[k]);
    end
  endtask

  task automatic wait_done(input int target, input string test);
    int waited;
    waited = 0;
    while (scoreboard_inst.done_count < target && waited < DONE_TIMEOUT) begin
      @(posedge CLK);
      waited++;
    end
    if (scoreboard_inst.done_count < target) begin
      scoreboard_inst.record_failure(
        $sformatf("Timeout in %s: move_done never arrived", test));
    end
  endtask

  task automatic track_position(input logic [MOTORS-1:0] dirs, input int n [MOTORS]);
    for (int a = 0; a < MOTORS; a++) begin
      position[a] = dirs[a] ? position[a] + n[a] : position[a] - n[a];
    end
  endtask

  initial begin
    stepper_pkg::word_t rx;
    stepper_pkg::word_t inc [MOTORS];
    stepper_pkg::word_t acc [MOTORS];
    stepper_pkg::word_t inc_b [MOTORS];
    logic [MOTORS-1:0]  dirs;
    int                 exp_n [MOTORS];
    int                 start [MOTORS];
    int                 done0;
    int                 falls0;
    CLK    = 1'b0;
    resetn = 1'b0;
    sck    = 1'b0;
    cs_n   = 1'b1;
    copi   = 1'b0;
    seed   = 32'ha373_1ab7;
    for (int a = 0; a < MOTORS; a++) begin
      position[a] = 0;
    end
    wait_clks(16);
    resetn <= 1'b1;
    wait_clks(4);

    scoreboard_inst.compare("reset enable", '0, 64'(enable));
    scoreboard_inst.compare("reset buffer_dtr", 1, 64'(buffer_dtr));
    scoreboard_inst.compare("reset step", '0, 64'(step));
    scoreboard_inst.compare("reset cipo", '0, 64'(cipo));
    spi_xfer({stepper_pkg::CMD_API_VERSION, 56'd0}, rx);
    spi_xfer('0, rx);
    scoreboard_inst.compare("version reply",
      {32'd0, stepper_pkg::VERSION_DEVEL, stepper_pkg::VERSION_MAJOR,
       stepper_pkg::VERSION_MINOR, stepper_pkg::VERSION_PATCH}, rx);
    scoreboard_inst.end_test("reset_and_version");

    dirs = MOTORS'($random(seed));
    spi_xfer({stepper_pkg::CMD_MOTOR_ENABLE, 56'(dirs)}, rx);
    scoreboard_inst.compare("enable bits", 64'(dirs), 64'(enable));
    scoreboard_inst.end_test("motor_enable");

    // Constant velocity, below one step per tick
    dirs  = MOTORS'($random(seed));
    done0 = scoreboard_inst.done_count;
    for (int a = 0; a < MOTORS; a++) begin
      inc[a]   = {33'd0, 31'($random(seed))} | 64'h1000_0000;
      acc[a]   = '0;
      exp_n[a] = expected_steps(inc[a], acc[a], 100);
      start[a] = scoreboard_inst.step_total[a];
    end
    send_move(dirs, 100, inc, acc);
    scoreboard_inst.compare("single_move dir", 64'(dirs), 64'(dir));
    wait_done(done0 + 1, "single_move");
    wait_clks(50);
    for (int a = 0; a < MOTORS; a++) begin
      scoreboard_inst.compare($sformatf("single_move steps axis %0d", a), 64'(exp_n[a]),
                              64'(scoreboard_inst.step_total[a] - start[a]));
    end
    scoreboard_inst.compare("single_move done count", 1,
                            64'(scoreboard_inst.done_count - done0));
    track_position(dirs, exp_n);
    scoreboard_inst.end_test("single_move");

    // Accel large enough to add several steps over the move
    dirs  = MOTORS'($random(seed));
    done0 = scoreboard_inst.done_count;
    for (int a = 0; a < MOTORS; a++) begin
      inc[a]   = {36'd0, 28'($random(seed))};
      acc[a]   = {40'd0, 24'($random(seed))} | 64'h80_0000;
      exp_n[a] = expected_steps(inc[a], acc[a], 100);
      start[a] = scoreboard_inst.step_total[a];
    end
    send_move(dirs, 100, inc, acc);
    // Replies carry counts after the previous move
    for (int a = 0; a < MOTORS; a++) begin
      scoreboard_inst.compare($sformatf("readback count axis %0d", a),
                              {{32{position[a][31]}}, position[a]}, reply[2 + 2 * a]);
      scoreboard_inst.compare($sformatf("readback zero slot %0d", a), '0, reply[3 + 2 * a]);
    end
    wait_done(done0 + 1, "accel_move");
    wait_clks(50);
    for (int a = 0; a < MOTORS; a++) begin
      scoreboard_inst.compare($sformatf("accel_move steps axis %0d", a), 64'(exp_n[a]),
                              64'(scoreboard_inst.step_total[a] - start[a]));
    end
    track_position(dirs, exp_n);
    scoreboard_inst.end_test("accel_move_and_readback");

    dirs   = MOTORS'($random(seed));
    done0  = scoreboard_inst.done_count;
    falls0 = scoreboard_inst.dtr_falls;
    for (int a = 0; a < MOTORS; a++) begin
      inc[a]   = {33'd0, 31'($random(seed))};
      inc_b[a] = {33'd0, 31'($random(seed))};
      acc[a]   = '0;
      exp_n[a] = expected_steps(inc[a], acc[a], 200) + expected_steps(inc_b[a], acc[a], 200);
      start[a] = scoreboard_inst.step_total[a];
    end
    send_move(dirs, 200, inc, acc);
    send_move(dirs, 200, inc_b, acc);
    wait_done(done0 + 2, "back_to_back");
    wait_clks(50);
    scoreboard_inst.compare("back_to_back buffer full seen", 1,
                            64'(scoreboard_inst.dtr_falls > falls0));
    scoreboard_inst.compare("back_to_back buffer_dtr", 1, 64'(buffer_dtr));
    scoreboard_inst.compare("back_to_back done count", 2,
                            64'(scoreboard_inst.done_count - done0));
    for (int a = 0; a < MOTORS; a++) begin
      scoreboard_inst.compare($sformatf("back_to_back steps axis %0d", a), 64'(exp_n[a]),
                              64'(scoreboard_inst.step_total[a] - start[a]));
    end
    track_position(dirs, exp_n);
    scoreboard_inst.end_test("back_to_back");

    // Long first move keeps the buffer full until the short one is queued
    spi_xfer({stepper_pkg::CMD_CLK_DIVISOR, 56'd8}, rx);
    done0 = scoreboard_inst.done_count;
    send_move(dirs, 600, inc, acc);
    send_move(dirs, 50, inc_b, acc);
    wait_done(done0 + 2, "divisor_timing");
    scoreboard_inst.compare_range("divisor_timing duration", 50 * 8 - 8, 50 * 8 + 8,
      scoreboard_inst.last_done_cycle - scoreboard_inst.last_rise_cycle);
    scoreboard_inst.end_test("divisor_timing");

    scoreboard_inst.report();
    if (scoreboard_inst.error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
